// File: src/mvm_defs.svh
`ifndef MVM_DEFS_SVH
`define MVM_DEFS_SVH

// matrix geometry
`define MVM_DIM        8
`define MVM_BYTE_W     8

// external memory port
`define MVM_WORD_W     64
`define MVM_ADDR_W     32

// 8 products of 255*255 fit in 24 bits
`define MVM_ACC_W      24
`define MVM_FIFO_DEPTH 8

// active low segments, all dark
`define MVM_SEG_OFF    7'b1111111

`endif

// File: src/mem_pkg.sv
`include "mvm_defs.svh"

package mem_pkg;

  // ====================
  // memory request
  // ====================

  // read strobe and word address, held while waitrequest is high
  typedef struct packed {
    logic                   read;
    logic [`MVM_ADDR_W-1:0] address;
  } mem_req_t;

  // ====================
  // memory response
  // ====================

  // one readdatavalid pulse per accepted read
  typedef struct packed {
    logic [`MVM_WORD_W-1:0] readdata;
    logic                   readdatavalid;
    logic                   waitrequest;
  } mem_rsp_t;

endpackage

// File: src/mvm_pkg.sv
`include "mvm_defs.svh"

package mvm_pkg;

  // fifo target index, 0 is B and 1..DIM are A rows
  localparam int TGT_W = $clog2(`MVM_DIM + 1);

  // loader FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_PUSH,
    S_CLEAR,
    S_RUN,
    S_DONE
  } load_state_t;

  typedef logic [`MVM_BYTE_W-1:0] byte_t;
  typedef logic [`MVM_ACC_W-1:0]  acc_t;

  // one byte written into one fifo
  typedef struct packed {
    logic             valid;
    logic [TGT_W-1:0] target;
    byte_t            data;
  } push_t;

  typedef struct packed {
    logic pop;
    logic clr;
  } lane_ctrl_t;

  typedef logic [6:0] seg_t;

endpackage

// File: src/byte_fifo.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module byte_fifo #(
  parameter int DEPTH = `MVM_FIFO_DEPTH
) (
  input  logic           CLOCK_50,
  input  logic           KEY,
  input  logic           wr,
  input  logic           rd,
  input  mvm_pkg::byte_t din,
  output mvm_pkg::byte_t dout,
  output logic           full,
  output logic           empty
);

  localparam int PTR_W = $clog2(DEPTH);

  mvm_pkg::byte_t mem [DEPTH];

  // extra msb tells a full buffer from an empty one
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           do_wr;
  logic           do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage and read data
  always_ff @(posedge CLOCK_50) begin
    if (do_wr) mem[wr_ptr[PTR_W-1:0]] <= din;
    if (do_rd) dout <= mem[rd_ptr[PTR_W-1:0]];
  end

endmodule

// File: src/matrix_loader.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module matrix_loader (
  input  logic                CLOCK_50,
  input  logic                KEY,
  output mem_pkg::mem_req_t   mem_req,
  input  mem_pkg::mem_rsp_t   mem_rsp,
  output mvm_pkg::push_t      push,
  output mvm_pkg::lane_ctrl_t lane_ctrl,
  output logic                done
);

  localparam int CNT_W = $clog2(`MVM_DIM);

  // word 0 is B, words 1..DIM are the A rows
  localparam logic [mvm_pkg::TGT_W-1:0] LAST_WORD = mvm_pkg::TGT_W'(`MVM_DIM);
  localparam logic [CNT_W-1:0]          LAST_BYTE = CNT_W'(`MVM_DIM - 1);

  mvm_pkg::load_state_t          state;
  logic [mvm_pkg::TGT_W-1:0]     word_cnt;
  logic [CNT_W-1:0]              byte_cnt;
  logic [`MVM_WORD_W-1:0]        word_q;

  // ====================
  // control FSM
  // ====================

  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      state    <= mvm_pkg::S_IDLE;
      word_cnt <= '0;
      byte_cnt <= '0;
      done     <= 1'b0;
    end else begin
      // registered so done follows the final accumulate
      done <= (state == mvm_pkg::S_DONE);
      case (state)
        mvm_pkg::S_IDLE: begin
          state <= mvm_pkg::S_REQ;
        end
        mvm_pkg::S_REQ: begin
          // hold read until the memory takes it
          if (!mem_rsp.waitrequest) state <= mvm_pkg::S_WAIT;
        end
        mvm_pkg::S_WAIT: begin
          if (mem_rsp.readdatavalid) begin
            byte_cnt <= '0;
            state    <= mvm_pkg::S_PUSH;
          end
        end
        mvm_pkg::S_PUSH: begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == LAST_BYTE) begin
            if (word_cnt == LAST_WORD) begin
              state <= mvm_pkg::S_CLEAR;
            end else begin
              word_cnt <= word_cnt + 1'b1;
              state    <= mvm_pkg::S_REQ;
            end
          end
        end
        mvm_pkg::S_CLEAR: begin
          byte_cnt <= '0;
          state    <= mvm_pkg::S_RUN;
        end
        mvm_pkg::S_RUN: begin
          // byte_cnt now counts pops
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == LAST_BYTE) state <= mvm_pkg::S_DONE;
        end
        mvm_pkg::S_DONE: begin
          state <= mvm_pkg::S_DONE;
        end
        default: begin
          state <= mvm_pkg::S_IDLE;
        end
      endcase
    end
  end

  // word latch
  always_ff @(posedge CLOCK_50) begin
    if (state == mvm_pkg::S_WAIT && mem_rsp.readdatavalid) begin
      word_q <= mem_rsp.readdata;
    end
  end

  // ====================
  // outputs
  // ====================

  assign mem_req.read    = (state == mvm_pkg::S_REQ);
  assign mem_req.address = `MVM_ADDR_W'(word_cnt);

  // msb first unpacking
  assign push.valid  = (state == mvm_pkg::S_PUSH);
  assign push.target = word_cnt;
  assign push.data   = word_q[`MVM_WORD_W-1 - byte_cnt*`MVM_BYTE_W -: `MVM_BYTE_W];

  assign lane_ctrl.clr = (state == mvm_pkg::S_CLEAR);
  assign lane_ctrl.pop = (state == mvm_pkg::S_RUN);

endmodule

// File: src/mac_array.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module mac_array (
  input  logic                CLOCK_50,
  input  logic                KEY,
  input  mvm_pkg::push_t      push,
  input  mvm_pkg::lane_ctrl_t lane_ctrl,
  output mvm_pkg::acc_t       results [`MVM_DIM]
);

  // fifo 0 holds B, fifo i+1 holds row i of A
  localparam int NFIFO = `MVM_DIM + 1;

  logic [NFIFO-1:0]    wr;
  logic [NFIFO-1:0]    empty;
  mvm_pkg::byte_t      fifo_out [NFIFO];
  logic [`MVM_DIM-1:0] lane_en;

  // target decode
  always_comb begin
    for (int j = 0; j < NFIFO; j++) begin
      wr[j] = push.valid && (push.target == mvm_pkg::TGT_W'(j));
    end
  end

  for (genvar j = 0; j < NFIFO; j++) begin : g_fifo
    byte_fifo u_fifo (
      .CLOCK_50 (CLOCK_50),
      .KEY      (KEY),
      .wr       (wr[j]),
      .rd       (lane_ctrl.pop),
      .din      (push.data),
      .dout     (fifo_out[j]),
      .full     (),
      .empty    (empty[j])
    );
  end

  // fifo data shows up one cycle after the pop
  always_ff @(posedge CLOCK_50 or negedge KEY) begin
    if (!KEY) begin
      lane_en <= '0;
    end else begin
      for (int i = 0; i < `MVM_DIM; i++) begin
        lane_en[i] <= lane_ctrl.pop && !empty[0] && !empty[i+1];
      end
    end
  end

  // ====================
  // mac lanes
  // ====================

  for (genvar i = 0; i < `MVM_DIM; i++) begin : g_lane
    logic [2*`MVM_BYTE_W-1:0] prod;
    mvm_pkg::acc_t            acc_q;

    assign prod = fifo_out[i+1] * fifo_out[0];

    always_ff @(posedge CLOCK_50 or negedge KEY) begin
      if (!KEY) begin
        acc_q <= '0;
      end else if (lane_ctrl.clr) begin
        acc_q <= '0;
      end else if (lane_en[i]) begin
        acc_q <= acc_q + prod;
      end
    end

    assign results[i] = acc_q;
  end

endmodule

// File: src/hex_display.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module hex_display (
  input  mvm_pkg::acc_t results [`MVM_DIM],
  input  logic          done,
  input  logic [9:0]    SW,
  output mvm_pkg::seg_t HEX0,
  output mvm_pkg::seg_t HEX1,
  output mvm_pkg::seg_t HEX2,
  output mvm_pkg::seg_t HEX3,
  output mvm_pkg::seg_t HEX4,
  output mvm_pkg::seg_t HEX5
);

  localparam int NDIG = `MVM_ACC_W / 4;

  // hex digit to active low segments
  function automatic mvm_pkg::seg_t seg_of(input logic [3:0] nib);
    case (nib)
      4'h0:    seg_of = 7'b1000000;
      4'h1:    seg_of = 7'b1111001;
      4'h2:    seg_of = 7'b0100100;
      4'h3:    seg_of = 7'b0110000;
      4'h4:    seg_of = 7'b0011001;
      4'h5:    seg_of = 7'b0010010;
      4'h6:    seg_of = 7'b0000010;
      4'h7:    seg_of = 7'b1111000;
      4'h8:    seg_of = 7'b0000000;
      4'h9:    seg_of = 7'b0011000;
      4'ha:    seg_of = 7'b0001000;
      4'hb:    seg_of = 7'b0000011;
      4'hc:    seg_of = 7'b1000110;
      4'hd:    seg_of = 7'b0100001;
      4'he:    seg_of = 7'b0000110;
      default: seg_of = 7'b0001110;
    endcase
  endfunction

  mvm_pkg::acc_t sel_res;
  logic          show;
  mvm_pkg::seg_t digit [NDIG];

  // SW[3:1] picks the row, SW[0] enables the display
  assign sel_res = results[SW[3:1]];
  assign show    = done && SW[0];

  always_comb begin
    for (int d = 0; d < NDIG; d++) begin
      digit[d] = show ? seg_of(sel_res[4*d +: 4]) : `MVM_SEG_OFF;
    end
  end

  // HEX0 carries the low nibble
  assign HEX0 = digit[0];
  assign HEX1 = digit[1];
  assign HEX2 = digit[2];
  assign HEX3 = digit[3];
  assign HEX4 = digit[4];
  assign HEX5 = digit[5];

endmodule

// File: src/minilab_top.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module minilab_top (
  input  logic                   CLOCK_50,
  input  logic                   KEY,
  input  logic [9:0]             SW,
  output logic                   LEDR,
  output mvm_pkg::seg_t          HEX0,
  output mvm_pkg::seg_t          HEX1,
  output mvm_pkg::seg_t          HEX2,
  output mvm_pkg::seg_t          HEX3,
  output mvm_pkg::seg_t          HEX4,
  output mvm_pkg::seg_t          HEX5,
  output logic                   mem_read,
  output logic [`MVM_ADDR_W-1:0] mem_address,
  input  logic [`MVM_WORD_W-1:0] mem_readdata,
  input  logic                   mem_readdatavalid,
  input  logic                   mem_waitrequest
);

  mem_pkg::mem_req_t   mem_req;
  mem_pkg::mem_rsp_t   mem_rsp;
  mvm_pkg::push_t      push;
  mvm_pkg::lane_ctrl_t lane_ctrl;
  mvm_pkg::acc_t       results [`MVM_DIM];
  logic                done;

  // memory port pins
  assign mem_read    = mem_req.read;
  assign mem_address = mem_req.address;
  assign mem_rsp     = '{readdata:      mem_readdata,
                         readdatavalid: mem_readdatavalid,
                         waitrequest:   mem_waitrequest};

  // done lamp
  assign LEDR = done;

  matrix_loader u_loader (
    .CLOCK_50  (CLOCK_50),
    .KEY       (KEY),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .push      (push),
    .lane_ctrl (lane_ctrl),
    .done      (done)
  );

  mac_array u_array (
    .CLOCK_50  (CLOCK_50),
    .KEY       (KEY),
    .push      (push),
    .lane_ctrl (lane_ctrl),
    .results   (results)
  );

  hex_display u_display (
    .results (results),
    .done    (done),
    .SW      (SW),
    .HEX0    (HEX0),
    .HEX1    (HEX1),
    .HEX2    (HEX2),
    .HEX3    (HEX3),
    .HEX4    (HEX4),
    .HEX5    (HEX5)
  );

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module tb_mem_model (
  input  logic                               CLOCK_50,
  input  logic                               KEY,
  input  logic                               read,
  input  logic [`MVM_ADDR_W-1:0]             address,
  input  logic [`MVM_DIM:0][`MVM_WORD_W-1:0] words,
  output logic [`MVM_WORD_W-1:0]             readdata,
  output logic                               readdatavalid,
  output logic                               waitrequest
);

  logic [31:0]            rng;
  logic [1:0]             stall_left;
  logic [2:0]             lat_left;
  logic                   busy;
  logic [`MVM_ADDR_W-1:0] addr_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // held high while a read is in flight so only one is outstanding
  assign waitrequest = busy || (stall_left != 2'd0);

  always @(posedge CLOCK_50 or negedge KEY) begin : seq
    logic [31:0] nxt;
    if (!KEY) begin
      rng           <= 32'd61;
      stall_left    <= 2'd2;
      lat_left      <= 3'd0;
      busy          <= 1'b0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end else begin
      nxt = xorshift32(rng);
      rng <= nxt;
      readdatavalid <= 1'b0;
      if (busy) begin
        // one data pulse, then pick the stall for the next read
        if (lat_left == 3'd1) begin
          busy          <= 1'b0;
          readdatavalid <= 1'b1;
          readdata      <= words[addr_q];
          stall_left    <= nxt[1:0];
        end
        lat_left <= lat_left - 1'b1;
      end else if (read) begin
        if (stall_left != 2'd0) begin
          stall_left <= stall_left - 1'b1;
        end else begin
          busy     <= 1'b1;
          addr_q   <= address;
          lat_left <= {1'b0, nxt[3:2]} + 3'd1;
        end
      end
    end
  end

endmodule

// File: tests/tb_minilab.sv
`timescale 1ns/1ps
`include "mvm_defs.svh"

module tb_minilab;

  localparam int NWORDS = `MVM_DIM + 1;
  // two runs, nine words at up to 20 cycles each, plus slack
  localparam int WATCHDOG_CYCLES = 2 * NWORDS * 20 + 100;

  logic                               CLOCK_50;
  logic                               KEY;
  logic [9:0]                         SW;
  logic                               LEDR;
  mvm_pkg::seg_t                      hex [6];
  logic                               mem_read;
  logic [`MVM_ADDR_W-1:0]             mem_address;
  logic [`MVM_WORD_W-1:0]             mem_readdata;
  logic                               mem_readdatavalid;
  logic                               mem_waitrequest;
  logic [`MVM_DIM:0][`MVM_WORD_W-1:0] mem_words;
  logic [`MVM_ADDR_W-1:0]             exp_addr;
  logic [`MVM_ADDR_W-1:0]             prev_addr;
  logic                               prev_stall;
  int                                 check_count;
  int                                 error_count;
  string                              waiting_for;

  minilab_top dut_i (
    .CLOCK_50          (CLOCK_50),
    .KEY               (KEY),
    .SW                (SW),
    .LEDR              (LEDR),
    .HEX0              (hex[0]),
    .HEX1              (hex[1]),
    .HEX2              (hex[2]),
    .HEX3              (hex[3]),
    .HEX4              (hex[4]),
    .HEX5              (hex[5]),
    .mem_read          (mem_read),
    .mem_address       (mem_address),
    .mem_readdata      (mem_readdata),
    .mem_readdatavalid (mem_readdatavalid),
    .mem_waitrequest   (mem_waitrequest)
  );

  tb_mem_model u_mem (
    .CLOCK_50      (CLOCK_50),
    .KEY           (KEY),
    .read          (mem_read),
    .address       (mem_address),
    .words         (mem_words),
    .readdata      (mem_readdata),
    .readdatavalid (mem_readdatavalid),
    .waitrequest   (mem_waitrequest)
  );

  always #5 CLOCK_50 = ~CLOCK_50;

  // ====================
  // reference model
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // active low with segment g in the msb
  function automatic mvm_pkg::seg_t nibble_to_seg(input logic [3:0] nib);
    mvm_pkg::seg_t table_q [16];
    table_q = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
    return table_q[nib];
  endfunction

  // row i is word i+1, B is word 0, byte k sits msb first
  function automatic mvm_pkg::acc_t ref_result(input int row);
    mvm_pkg::acc_t  sum;
    mvm_pkg::byte_t a;
    mvm_pkg::byte_t b;
    sum = '0;
    for (int k = 0; k < `MVM_DIM; k++) begin
      b   = mem_words[0][`MVM_WORD_W-1 - k*`MVM_BYTE_W -: `MVM_BYTE_W];
      a   = mem_words[row+1][`MVM_WORD_W-1 - k*`MVM_BYTE_W -: `MVM_BYTE_W];
      sum = sum + a * b;
    end
    return sum;
  endfunction

  // unknown patterns decode to x
  function automatic mvm_pkg::acc_t decode_digits();
    mvm_pkg::acc_t val;
    val = 'x;
    for (int d = 0; d < 6; d++) begin
      for (int n = 0; n < 16; n++) begin
        if (nibble_to_seg(4'(n)) === hex[d]) val[4*d +: 4] = 4'(n);
      end
    end
    return val;
  endfunction

  // ====================
  // compare tasks
  // ====================

  task automatic check_seg(input string name, input mvm_pkg::seg_t got,
                           input mvm_pkg::seg_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input string name, input mvm_pkg::acc_t got,
                              input mvm_pkg::acc_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [`MVM_ADDR_W-1:0] got,
                            input logic [`MVM_ADDR_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_all_off();
    for (int d = 0; d < 6; d++) begin
      check_seg($sformatf("HEX%0d", d), hex[d], `MVM_SEG_OFF);
    end
  endtask

  // ====================
  // sequences
  // ====================

  task automatic fill_memory(input bit all_ones);
    logic [31:0] x;
    logic [31:0] hi;
    x = 32'd61;
    for (int w = 0; w < NWORDS; w++) begin
      x  = xorshift32(x);
      hi = x;
      x  = xorshift32(x);
      mem_words[w] <= all_ones ? {`MVM_WORD_W{1'b1}} : {hi, x};
    end
  endtask

  task automatic apply_reset(input bit all_ones);
    waiting_for = "the reset sequence";
    @(posedge CLOCK_50);
    KEY <= 1'b0;
    SW  <= 10'h001;
    fill_memory(all_ones);
    repeat (16) begin
      @(negedge CLOCK_50);
      check_bit("LEDR", LEDR, 1'b0);
      check_bit("mem_read", mem_read, 1'b0);
      check_all_off();
    end
    @(posedge CLOCK_50);
    KEY <= 1'b1;
    @(negedge CLOCK_50);
    check_bit("LEDR", LEDR, 1'b0);
    check_bit("mem_read", mem_read, 1'b0);
    check_all_off();
    // first read by the second cycle
    @(negedge CLOCK_50);
    check_bit("mem_read", mem_read, 1'b1);
  endtask

  // display stays dark for every SW value until LEDR rises
  task automatic wait_for_done();
    waiting_for = "LEDR to rise after the load";
    while (LEDR !== 1'b1) begin
      check_all_off();
      @(posedge CLOCK_50);
      SW <= SW + 10'd1;
      @(negedge CLOCK_50);
    end
    check_addr("accepted reads", exp_addr, NWORDS);
    check_bit("mem_read", mem_read, 1'b0);
  endtask

  task automatic check_rows(input bit all_ones);
    mvm_pkg::acc_t exp;
    waiting_for = "the display checks";
    for (int row = 0; row < `MVM_DIM; row++) begin
      @(posedge CLOCK_50);
      SW <= {6'b0, 3'(row), 1'b1};
      @(negedge CLOCK_50);
      exp = ref_result(row);
      for (int d = 0; d < 6; d++) begin
        check_seg($sformatf("HEX%0d", d), hex[d], nibble_to_seg(exp[4*d +: 4]));
      end
      check_result($sformatf("row %0d", row), decode_digits(), exp);
      // 8 * 255 * 255
      if (all_ones) check_result($sformatf("row %0d max", row), decode_digits(), 24'd520200);
    end
    @(posedge CLOCK_50);
    SW <= 10'h00e;
    @(negedge CLOCK_50);
    check_all_off();
    check_bit("LEDR", LEDR, 1'b1);
  endtask

  // address order and stability under waitrequest
  always @(negedge CLOCK_50) begin
    if (!KEY) begin
      exp_addr   = '0;
      prev_stall = 1'b0;
    end else begin
      if (prev_stall) begin
        check_bit("mem_read", mem_read, 1'b1);
        check_addr("mem_address", mem_address, prev_addr);
      end
      if (mem_read && !mem_waitrequest) begin
        check_addr("mem_address", mem_address, exp_addr);
        exp_addr = exp_addr + 1'b1;
      end
      prev_stall = mem_read && mem_waitrequest;
      prev_addr  = mem_address;
    end
  end

  initial begin
    CLOCK_50    = 1'b0;
    KEY         = 1'b1;
    SW          = '0;
    mem_words   = '0;
    exp_addr    = '0;
    prev_addr   = '0;
    prev_stall  = 1'b0;
    check_count = 0;
    error_count = 0;
    waiting_for = "start";
    apply_reset(1'b0);
    wait_for_done();
    check_rows(1'b0);
    apply_reset(1'b1);
    wait_for_done();
    check_rows(1'b1);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout: the run stalled while waiting for %s", waiting_for);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/mem_pkg.sv
src/mvm_pkg.sv
src/byte_fifo.sv
src/matrix_loader.sv
src/mac_array.sv
src/hex_display.sv
src/minilab_top.sv
tests/tb_mem_model.sv
tests/tb_minilab.sv
